// ==== rtl/vic_clk_pkg.sv ====
`default_nettype none

package vic_clk_pkg;

    // chip codes, same numbering the video core expects on its chip input
    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,  // ntsc, 65 cycles per line
        CHIP6567R56A = 2'd1,  // old ntsc, 64 cycles per line, no strap selects it
        CHIP6569     = 2'd2   // pal
    } chip_t;

    // strap codes, sampled while internal_rst is high
    typedef enum logic [1:0] {
        MODE_SYS_PAL  = 2'd0,  // on-board oscillator, pal timing
        MODE_SYS_NTSC = 2'd1,  // on-board oscillator, ntsc timing
        MODE_EXT_PAL  = 2'd2,  // external pal crystal
        MODE_EXT_NTSC = 2'd3   // external ntsc crystal
    } mode_t;

    localparam int unsigned NCO_W = 24;  // phase accumulator width

    // frequency words = f_strobe / f_sys * 2**NCO_W, all below 2**(NCO_W-1)
    // sys modes: sys_clockb stands for a 125 MHz board clock
    localparam logic [NCO_W-1:0] DOT_INC_SYS_PAL  = 24'd4231610;  // 31.527955 MHz
    localparam logic [NCO_W-1:0] COL_INC_SYS_PAL  = 24'd2380281;  // 17.734475 MHz
    localparam logic [NCO_W-1:0] DOT_INC_SYS_NTSC = 24'd4392580;  // 32.727272 MHz
    localparam logic [NCO_W-1:0] COL_INC_SYS_NTSC = 24'd1921754;  // 14.318181 MHz

    // ext modes: sys_clockb stands for 8x the external 4x color crystal,
    // so the ratios come out exact (dot4x = 16/9 or 16/7 of col4x)
    localparam logic [NCO_W-1:0] DOT_INC_EXT_PAL  = 24'h38E38E;  // 2/9 of sys
    localparam logic [NCO_W-1:0] COL_INC_EXT_PAL  = 24'h200000;  // 1/8 of sys
    localparam logic [NCO_W-1:0] DOT_INC_EXT_NTSC = 24'h492492;  // 2/7 of sys
    localparam logic [NCO_W-1:0] COL_INC_EXT_NTSC = 24'h200000;  // 1/8 of sys

    // reset stretch, short stand-in for the power-on counter and pll lock
    localparam int unsigned RST_HOLD = 64;
    localparam int unsigned RST_CNT_W = $clog2(RST_HOLD + 1);
    localparam logic [RST_CNT_W-1:0] RST_HOLD_CNT = RST_CNT_W'(RST_HOLD);

    // latched board config, 2 + 24 + 24 = 50 bits
    typedef struct packed {
        chip_t            chip;     // chip code handed to the core
        logic [NCO_W-1:0] dot_inc;  // dot4x oscillator word
        logic [NCO_W-1:0] col_inc;  // col4x oscillator word
    } clk_cfg_t;

endpackage : vic_clk_pkg

`default_nettype wire

// ==== rtl/clk_mode_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_mode_select (
    input  logic                  sys_clockb,
    input  logic                  internal_rst,
    input  vic_clk_pkg::mode_t    video_std,    // board strap, a level
    output vic_clk_pkg::clk_cfg_t cfg
);

    vic_clk_pkg::clk_cfg_t cfg_next;  // decoded strap, not yet latched

    // strap decode, every code maps so no illegal case exists
    always_comb begin
        cfg_next.chip    = vic_clk_pkg::CHIP6569;  // default follows sys pal
        cfg_next.dot_inc = vic_clk_pkg::DOT_INC_SYS_PAL;
        cfg_next.col_inc = vic_clk_pkg::COL_INC_SYS_PAL;
        case (video_std)
            vic_clk_pkg::MODE_SYS_PAL: begin
                cfg_next.chip    = vic_clk_pkg::CHIP6569;
                cfg_next.dot_inc = vic_clk_pkg::DOT_INC_SYS_PAL;
                cfg_next.col_inc = vic_clk_pkg::COL_INC_SYS_PAL;
            end
            vic_clk_pkg::MODE_SYS_NTSC: begin
                cfg_next.chip    = vic_clk_pkg::CHIP6567R8;
                cfg_next.dot_inc = vic_clk_pkg::DOT_INC_SYS_NTSC;
                cfg_next.col_inc = vic_clk_pkg::COL_INC_SYS_NTSC;
            end
            vic_clk_pkg::MODE_EXT_PAL: begin
                cfg_next.chip    = vic_clk_pkg::CHIP6569;
                cfg_next.dot_inc = vic_clk_pkg::DOT_INC_EXT_PAL;
                cfg_next.col_inc = vic_clk_pkg::COL_INC_EXT_PAL;
            end
            vic_clk_pkg::MODE_EXT_NTSC: begin
                cfg_next.chip    = vic_clk_pkg::CHIP6567R8;
                cfg_next.dot_inc = vic_clk_pkg::DOT_INC_EXT_NTSC;
                cfg_next.col_inc = vic_clk_pkg::COL_INC_EXT_NTSC;
            end
        endcase
    end

    // strap latch: track the pin during reset, freeze once reset drops
    // a strap change in normal run only lands at the next internal_rst
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            cfg <= cfg_next;  // one cycle behind the strap
        end
    end

endmodule : clk_mode_select

`default_nettype wire

// ==== rtl/nco_strobe.sv ====
`timescale 1ns/1ps
`default_nettype none

module nco_strobe (
    input  logic                          sys_clockb,
    input  logic                          rst,     // subsystem reset, clears phase
    input  logic [vic_clk_pkg::NCO_W-1:0] inc,     // frequency word
    output logic                          strobe   // one-cycle clock enable
);

    logic [vic_clk_pkg::NCO_W-1:0] acc;  // phase
    logic [vic_clk_pkg::NCO_W:0]   sum;  // phase + word with carry bit on top

    assign sum = {1'b0, acc} + {1'b0, inc};

    // each wrap of the phase is one output period
    // inc stays under half scale so a wrap never happens two edges in a row
    always_ff @(posedge sys_clockb) begin
        if (rst) begin
            acc    <= '0;
            strobe <= 1'b0;
        end else begin
            acc    <= sum[vic_clk_pkg::NCO_W-1:0];  // drop the carry, keep phase
            strobe <= sum[vic_clk_pkg::NCO_W];      // carry out is the enable
        end
    end

endmodule : nco_strobe

`default_nettype wire

// ==== rtl/rst_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rst_sequencer (
    input  logic sys_clockb,
    input  logic internal_rst,  // raw board reset
    output logic rst            // stretched reset for the subsystem
);

    logic [vic_clk_pkg::RST_CNT_W-1:0] hold_cnt;  // edges left before release
    logic                              hold_busy;

    assign hold_busy = (hold_cnt != '0);

    // counter reloads for as long as internal_rst is seen high
    // first low edge starts the count, rst drops RST_HOLD + 1 edges later
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            hold_cnt <= vic_clk_pkg::RST_HOLD_CNT;
            rst      <= 1'b1;
        end else begin
            if (hold_busy) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            rst <= hold_busy;  // stays low once the count has run out
        end
    end

endmodule : rst_sequencer

`default_nettype wire

// ==== rtl/vic_clocking.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_clocking (
    input  logic               sys_clockb,
    input  logic               internal_rst,  // board reset, also the strap window
    input  vic_clk_pkg::mode_t video_std,     // clock and video standard strap
    output logic               dot4x_en,      // 4x dot rate enable on sys_clockb
    output logic               col4x_en,      // 4x color rate enable on sys_clockb
    output logic               rst,           // stretched reset out
    output vic_clk_pkg::chip_t chip           // chip code for the core
);

    vic_clk_pkg::clk_cfg_t cfg;  // latched strap config

    // strap latch and decode
    clk_mode_select i_clk_mode_select (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .video_std    (video_std),
        .cfg          (cfg)
    );

    // power-on style reset stretch
    rst_sequencer i_rst_sequencer (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .rst          (rst)
    );

    // dot4x enable, held quiet until rst drops
    nco_strobe i_dot_nco (
        .sys_clockb (sys_clockb),
        .rst        (rst),
        .inc        (cfg.dot_inc),
        .strobe     (dot4x_en)
    );

    // col4x enable, runs off the same phase start as the dot one
    nco_strobe i_col_nco (
        .sys_clockb (sys_clockb),
        .rst        (rst),
        .inc        (cfg.col_inc),
        .strobe     (col4x_en)
    );

    assign chip = cfg.chip;  // straight from the latch, no extra stage

endmodule : vic_clocking

`default_nettype wire

// ==== dv/vic_clocking_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_clocking_asserts (
    input logic               sys_clockb,
    input logic               internal_rst,
    input logic               rst,
    input logic               dot4x_en,
    input logic               col4x_en,
    input vic_clk_pkg::chip_t chip
);

    int unsigned fail_cnt = 0;  // rule failures so far

    // an edge that samples rst high clears both oscillators
    // so nothing may be seen on the edge after it
    a_quiet_in_reset: assert property (
        @(posedge sys_clockb) rst |=> (!dot4x_en && !col4x_en)
    ) else begin
        fail_cnt++;
        $error("strobe seen one edge after rst was high");
    end

    // the sequencer answers internal_rst on the very next edge
    a_rst_follows_input: assert property (
        @(posedge sys_clockb) internal_rst |=> rst
    ) else begin
        fail_cnt++;
        $error("rst low after internal_rst was sampled high");
    end

    // strap latch is frozen outside of internal_rst
    a_chip_held: assert property (
        @(posedge sys_clockb) !internal_rst |=> $stable(chip)
    ) else begin
        fail_cnt++;
        $error("chip moved while internal_rst was low");
    end

    // words stay under half scale, two wraps in a row cannot happen
    a_dot_not_adjacent: assert property (
        @(posedge sys_clockb) dot4x_en |=> !dot4x_en
    ) else begin
        fail_cnt++;
        $error("dot4x_en high on two edges in a row");
    end

    a_col_not_adjacent: assert property (
        @(posedge sys_clockb) col4x_en |=> !col4x_en
    ) else begin
        fail_cnt++;
        $error("col4x_en high on two edges in a row");
    end

endmodule : vic_clocking_asserts

`default_nettype wire

// ==== dv/vic_clocking_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_clocking_tb;

    localparam int MAX_CASES  = 32;  // room in the case memory
    localparam int CASE_WORDS = 6;   // hex words per case line
    localparam int RST_CYCLES = 8;   // internal_rst pulse length in clocks
    localparam int CLK_HALF   = 4;   // 8 ns period
    localparam int DRIVE_DLY  = 1;   // inputs move this long after posedge
    localparam int CASE_SLACK = 20;  // spare clocks per case for the timeout

    // one line of the case file
    typedef struct packed {
        vic_clk_pkg::mode_t strap;       // strap held during reset
        vic_clk_pkg::mode_t late_strap;  // strap driven once rst is low
        logic [15:0]        window;      // edges counted after rst drops
        vic_clk_pkg::chip_t chip;        // expected chip code
        logic [15:0]        dot_cnt;     // expected dot4x_en pulses in window
        logic [15:0]        col_cnt;     // expected col4x_en pulses in window
    } clk_case_t;

    logic               sys_clockb;
    logic               internal_rst;
    vic_clk_pkg::mode_t video_std;
    logic               dot4x_en;
    logic               col4x_en;
    logic               rst;
    vic_clk_pkg::chip_t chip;

    logic [15:0] case_mem [0:MAX_CASES*CASE_WORDS-1];  // raw file image
    clk_case_t   cases [0:MAX_CASES-1];
    int          n_cases;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;  // stays 0 until the cases are loaded

    vic_clocking i_vic_clocking (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .video_std    (video_std),
        .dot4x_en     (dot4x_en),
        .col4x_en     (col4x_en),
        .rst          (rst),
        .chip         (chip)
    );

    // rule checkers ride along inside the dut scope
    bind vic_clocking vic_clocking_asserts i_vic_clocking_asserts (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .rst          (rst),
        .dot4x_en     (dot4x_en),
        .col4x_en     (col4x_en),
        .chip         (chip)
    );

    initial begin
        sys_clockb = 1'b0;
        forever #(CLK_HALF) sys_clockb = ~sys_clockb;
    end

    // free running cycle count, ends a stuck run or one with a fired rule
    always @(posedge sys_clockb) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
        end else if (i_vic_clocking.i_vic_clocking_asserts.fail_cnt != 0) begin
            abort_run("a bound assertion on the dut failed");
        end
    end

    // failure that is not a value mismatch
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // one clock, then past the nba region so outputs are settled
    task automatic step_clock();
        @(posedge sys_clockb);
        #(DRIVE_DLY);
    endtask

    // pal straps give the 6569, ntsc straps the 6567r8
    function automatic int chip_for_strap(input vic_clk_pkg::mode_t strap);
        if (strap == vic_clk_pkg::MODE_SYS_NTSC || strap == vic_clk_pkg::MODE_EXT_NTSC) begin
            return int'(vic_clk_pkg::CHIP6567R8);
        end
        return int'(vic_clk_pkg::CHIP6569);
    endfunction

    task automatic load_cases();
        int          k;
        int          base;
        logic [15:0] strap_word;
        $readmemh("dv/clock_cases.txt", case_mem);
        n_cases = 0;
        for (k = 0; k < MAX_CASES; k++) begin
            base       = k * CASE_WORDS;
            strap_word = case_mem[base];
            if ($isunknown(strap_word)) begin
                abort_run("case file ended without the ffff end marker");
            end
            if (strap_word == 16'hffff) begin
                break;  // end marker
            end
            if (strap_word > 16'd3 || case_mem[base+1] > 16'd3) begin
                abort_run($sformatf("case %0d has a strap value outside 0 to 3", k));
            end
            if (case_mem[base+3] > 16'd2 || case_mem[base+2] == 16'd0) begin
                abort_run($sformatf("case %0d has a bad chip code or an empty window", k));
            end
            cases[k].strap      = vic_clk_pkg::mode_t'(strap_word[1:0]);
            cases[k].late_strap = vic_clk_pkg::mode_t'(case_mem[base+1][1:0]);
            cases[k].window     = case_mem[base+2];
            cases[k].chip       = vic_clk_pkg::chip_t'(case_mem[base+3][1:0]);
            cases[k].dot_cnt    = case_mem[base+4];
            cases[k].col_cnt    = case_mem[base+5];
            n_cases++;
        end
        if (n_cases == 0) begin
            abort_run("case file holds no cases");
        end
    endtask

    task automatic run_case(input int idx);
        clk_case_t c;
        string     tag;
        int        i;
        int        edges;
        int        quiet;
        int        dot_seen;
        int        col_seen;
        c        = cases[idx];
        tag      = $sformatf("case %0d strap %0d", idx, int'(c.strap));
        edges    = 0;
        quiet    = 0;
        dot_seen = 0;
        col_seen = 0;

        // the file and the chip rule must agree before the dut is asked
        check_val({tag, " chip column vs strap rule"}, chip_for_strap(c.strap), int'(c.chip));

        // reset pulse with the strap on the pin
        step_clock();
        internal_rst = 1'b1;
        video_std    = c.strap;
        for (i = 1; i <= RST_CYCLES; i++) begin
            step_clock();
            check_val({tag, " rst high during internal_rst"}, 1, int'(rst));
            if (i >= 2) begin  // first edge can still hold a strobe from the last run
                quiet += int'(dot4x_en) + int'(col4x_en);
            end
        end
        internal_rst = 1'b0;  // next edge is the first to sample it low
        check_val({tag, " chip latched from strap"}, int'(c.chip), int'(chip));

        // stretch, count edges until rst reads low
        do begin
            step_clock();
            edges++;
            quiet += int'(dot4x_en) + int'(col4x_en);
        end while (rst == 1'b1);
        check_val({tag, " rst release edge"}, int'(vic_clk_pkg::RST_HOLD) + 1, edges);
        check_val({tag, " strobes before rst low"}, 0, quiet);

        video_std = c.late_strap;  // must not reach chip or the oscillators

        // count strobes over the window
        for (i = 0; i < int'(c.window); i++) begin
            step_clock();
            check_val({tag, " rst stays low"}, 0, int'(rst));
            dot_seen += int'(dot4x_en);
            col_seen += int'(col4x_en);
        end
        check_val({tag, " chip after window"}, int'(c.chip), int'(chip));
        check_val({tag, " dot4x_en count"}, int'(c.dot_cnt), dot_seen);
        check_val({tag, " col4x_en count"}, int'(c.col_cnt), col_seen);
    endtask

    initial begin
        int k;
        int limit;
        internal_rst = 1'b1;  // board comes up in reset
        video_std    = vic_clk_pkg::MODE_SYS_PAL;
        load_cases();

        // reset pulse, stretch, window and slack for every case
        limit = 0;
        for (k = 0; k < n_cases; k++) begin
            limit += RST_CYCLES + int'(vic_clk_pkg::RST_HOLD) + int'(cases[k].window);
            limit += CASE_SLACK;
        end
        cycle_limit = limit;
        $display("running %0d cases, cycle limit %0d", n_cases, cycle_limit);

        for (k = 0; k < n_cases; k++) begin
            run_case(k);
        end

        // a rule can still fire on the last edge of the last window
        if (i_vic_clocking.i_vic_clocking_asserts.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "assertion failed");
        end
    end

endmodule : vic_clocking_tb

`default_nettype wire

// ==== dv/clock_cases.txt ====
// columns, all hex: strap late_strap window chip dot_cnt col_cnt
// counts are floor(window * inc / 2**24); chip 2 is the pal 6569, 0 the ntsc 6567r8
0 0 00c8 2 0032 001c   // sys pal, 200 edges
1 1 00c8 0 0034 0016   // sys ntsc, 200 edges
2 2 00b4 2 0027 0016   // ext pal, 180 edges, dot word just under 2/9
3 3 00d2 0 003b 001a   // ext ntsc, 210 edges, dot word just under 2/7
1 2 00c8 0 0034 0016   // strap moves to ext pal after reset, sys ntsc must stay
2 1 0168 2 004f 002d   // strap moves to sys ntsc after reset, ext pal must stay
0 0 0061 2 0018 000d   // sys pal, short odd window
3 3 0096 0 002a 0012   // ext ntsc, 150 edges
ffff                   // end marker

// ==== vic_clocking.f ====
rtl/vic_clk_pkg.sv
rtl/clk_mode_select.sv
rtl/nco_strobe.sv
rtl/rst_sequencer.sv
rtl/vic_clocking.sv
dv/vic_clocking_asserts.sv
dv/vic_clocking_tb.sv

// ==== Makefile ====
# Verilator build and run for the vic_clocking testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := vic_clocking_tb
FILELIST  := vic_clocking.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test FAILED, run ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
